/* id_pkg.sv */
package id_pkg;

  // identity port geometry
  localparam int id_bits  = 57;                  // device identifier length
  localparam int cap_bits = 64;                  // capture word, padded to 64
  localparam int pad_bits = cap_bits - id_bits;  // unused top bits of capture

  typedef logic [id_bits-1:0] id_t;              // raw identifier value
  typedef logic [1:0]         addr_t;            // host register address
  typedef logic [31:0]        word_t;            // host data word

  // host register map, address 3 is unmapped and reads zero
  localparam addr_t addr_status = 2'd0;          // busy / valid flags
  localparam addr_t addr_id_lo  = 2'd1;          // id bits 31:0
  localparam addr_t addr_id_hi  = 2'd2;          // id bits 56:32, zero-extended

  // reader status, busy lands in bit 1 and valid in bit 0
  typedef struct packed {
    logic busy;                                  // readout in progress
    logic valid;                                 // full identifier held
  } id_status_t;

  // field view of the capture word
  typedef struct packed {
    logic [pad_bits-1:0] pad;                    // stays zero, cleared on load
    id_t                 id;                     // bits as shifted in, msb first
  } dna_fields_t;

  // same 64 bits, shifted as raw and read back as fields
  typedef union packed {
    logic [cap_bits-1:0] raw;                    // shift view
    dna_fields_t         fields;                 // decoded view
  } dna_cap_u;

endpackage

/* dna_port_model.sv */
`timescale 1ns/1ns

// behavioral stand-in for the device identity shift register
module dna_port_model import id_pkg::*; #(
  parameter id_t sim_dna = '0                    // identifier loaded on port_load
) (
  input  logic dclk,
  input  logic rst,
  input  logic port_load,                        // one-cycle parallel load
  input  logic port_shift,                       // shift left one bit per cycle
  output logic port_dout                         // current msb
);

  id_t shreg;                                    // identity shift register

  always_ff @(posedge dclk) begin
    if (rst) begin
      shreg <= '0;                               // idle port shifts out zeros
    end else if (port_load) begin
      shreg <= sim_dna;                          // parallel load from parameter
    end else if (port_shift) begin
      shreg <= {shreg[id_bits-2:0], 1'b0};       // msb out, zero fill at lsb
    end
  end

  assign port_dout = shreg[id_bits-1];           // msb first

  // the real primitive gives load priority, the reader must never rely on it
  a_load_shift_excl: assert property (
    @(posedge dclk) disable iff (rst)
    !(port_load && port_shift)
  ) else $error("dna_port_model: port_load and port_shift high together");

endmodule

/* dna_reader.sv */
`timescale 1ns/1ns

module dna_reader import id_pkg::*; (
  input  logic       dclk,
  input  logic       rst,
  input  logic       start,                      // host level, rising edge starts a read
  output logic       port_load,                  // one-cycle load pulse to the port
  output logic       port_shift,                 // shift enable level to the port
  input  logic       port_dout,                  // serial bit from the port, msb first
  output id_t        id,                         // captured identifier
  output id_status_t status,                     // busy / valid
  output logic       done                        // one-cycle end-of-read pulse
);

  localparam int cnt_bits = $clog2(id_bits + 1); // holds 0..id_bits
  localparam logic [cnt_bits-1:0] last_bit = cnt_bits'(id_bits - 1);

  logic                start_s0;                 // first sync stage
  logic                start_s1;                 // second sync stage
  logic                start_s2;                 // delayed copy for edge detect
  logic                start_rise;               // synchronized rising edge of start
  logic                busy;                     // readout running
  logic                valid;                    // identifier complete
  logic [cnt_bits-1:0] bit_cnt;                  // bits captured so far
  dna_cap_u            cap;                      // capture word

  // start synchronizer and edge detector
  always_ff @(posedge dclk) begin
    if (rst) begin
      start_s0 <= 1'b0;
      start_s1 <= 1'b0;
      start_s2 <= 1'b0;
    end else begin
      start_s0 <= start;
      start_s1 <= start_s0;
      start_s2 <= start_s1;
    end
  end

  assign start_rise = start_s1 & ~start_s2;      // level held high gives one edge

  // load / shift sequencer
  always_ff @(posedge dclk) begin
    if (rst) begin
      port_load  <= 1'b0;
      port_shift <= 1'b0;
      busy       <= 1'b0;
      valid      <= 1'b0;
      done       <= 1'b0;
      bit_cnt    <= '0;
    end else begin
      done      <= 1'b0;                         // pulse only
      port_load <= 1'b0;                         // pulse only
      if (start_rise && !busy) begin             // edges during a read are dropped
        port_load <= 1'b1;
        busy      <= 1'b1;
        valid     <= 1'b0;                       // old id no longer trusted
      end
      if (port_load) begin                       // port loads this edge, shift next
        port_shift <= 1'b1;
        bit_cnt    <= '0;
      end
      if (port_shift) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == last_bit) begin           // last bit captured this edge
          port_shift <= 1'b0;
          busy       <= 1'b0;
          valid      <= 1'b1;
          done       <= 1'b1;
        end
      end
    end
  end

  // capture register, bits enter at the lsb of the raw view
  always_ff @(posedge dclk) begin
    if (port_load) begin
      cap.raw <= '0;                             // keeps pad bits at zero
    end else if (port_shift) begin
      cap.raw <= {cap.raw[cap_bits-2:0], port_dout};
    end
  end

  assign id     = cap.fields.id;                 // read back through the field view
  assign status = '{busy: busy, valid: valid};

  a_cnt_range: assert property (
    @(posedge dclk) disable iff (rst)
    bit_cnt <= id_bits
  ) else $error("dna_reader: bit counter past id_bits");

  a_done_single: assert property (
    @(posedge dclk) disable iff (rst)
    done |=> !done
  ) else $error("dna_reader: done held longer than one cycle");

  a_shift_busy: assert property (
    @(posedge dclk) disable iff (rst)
    port_shift |-> busy
  ) else $error("dna_reader: port_shift outside a readout");

endmodule

/* id_regs.sv */
`timescale 1ns/1ns

module id_regs import id_pkg::*; (
  input  logic       dclk,
  input  logic       rst,
  input  logic       rd,                         // one-cycle read strobe
  input  addr_t      rd_addr,                    // word address
  output word_t      rd_data,                    // valid one cycle after rd
  input  id_t        id,                         // identifier from the reader
  input  id_status_t status                      // busy / valid from the reader
);

  word_t rd_word;                                // decoded word for the current address
  word_t id_lo_word;                             // id bits 31:0, masked
  word_t id_hi_word;                             // id bits 56:32, masked

  // a partly shifted identifier never reaches the host
  assign id_lo_word = status.valid ? id[31:0] : '0;
  assign id_hi_word = status.valid ? word_t'(id[id_bits-1:32]) : '0;

  always_comb begin
    rd_word = '0;                                // unmapped address reads zero
    case (rd_addr)
      addr_status: rd_word = word_t'(status);    // bit 1 busy, bit 0 valid
      addr_id_lo:  rd_word = id_lo_word;
      addr_id_hi:  rd_word = id_hi_word;
      default:     rd_word = '0;
    endcase
  end

  // read data registered on rd and held between strobes
  always_ff @(posedge dclk) begin
    if (rst) begin
      rd_data <= '0;
    end else if (rd) begin
      rd_data <= rd_word;
    end
  end

  a_addr_known: assert property (
    @(posedge dclk) disable iff (rst)
    rd |-> !$isunknown(rd_addr)
  ) else $error("id_regs: rd_addr unknown during rd");

endmodule

/* id_top.sv */
`timescale 1ns/1ns

module id_top import id_pkg::*; #(
  parameter id_t sim_dna = 57'h1A5C396E2D07B4F   // identifier the port model returns
) (
  input  logic  dclk,
  input  logic  rst,
  input  logic  start,                           // rising edge starts a readout
  input  logic  rd,                              // host read strobe
  input  addr_t rd_addr,                         // host word address
  output word_t rd_data,                         // registered read data
  output logic  done                             // end-of-readout pulse
);

  logic       port_load;                         // reader -> port model
  logic       port_shift;                        // reader -> port model
  logic       port_dout;                         // port model -> reader
  id_t        id;                                // reader -> register file
  id_status_t status;                            // reader -> register file

  dna_port_model #(
    .sim_dna (sim_dna)
  ) i_dna_port_model (
    .dclk       (dclk),
    .rst        (rst),
    .port_load  (port_load),
    .port_shift (port_shift),
    .port_dout  (port_dout)
  );

  dna_reader i_dna_reader (
    .dclk       (dclk),
    .rst        (rst),
    .start      (start),
    .port_load  (port_load),
    .port_shift (port_shift),
    .port_dout  (port_dout),
    .id         (id),
    .status     (status),
    .done       (done)
  );

  id_regs i_id_regs (
    .dclk    (dclk),
    .rst     (rst),
    .rd      (rd),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .id      (id),
    .status  (status)
  );

endmodule

/* tb_id_top.sv */
`timescale 1ns/1ns

module tb_id_top import id_pkg::*;;

  localparam id_t dna_value      = 57'h1B36C2E9F407A15; // differs from the top default
  localparam int  clk_period     = 100;
  localparam int  n_readouts     = 10;                  // upper bound on readouts run below
  localparam int  readout_cycles = 80;                  // one readout is about 60 cycles
  localparam int  read_margin    = 1000;                // reads, gaps and idle checks
  localparam int  done_limit     = 100;                 // cycles allowed for one done

  logic  dclk;
  logic  rst;
  logic  start;
  logic  rd;
  addr_t rd_addr;
  word_t rd_data;
  logic  done;

  logic        exp_valid;                               // valid as the host should see it
  logic        exp_busy;                                // busy as the host should see it
  logic [31:0] rng;                                     // xorshift state
  word_t       exp_q[$];                                // expected words, oldest first
  addr_t       addr_q[$];                               // addresses of pending reads
  word_t       cmp_exp;
  addr_t       cmp_addr;
  int          done_count = 0;                          // done pulses seen so far
  int          done_before;
  logic        rd_taken = 1'b0;                         // rd was sampled on the last edge

  id_top #(
    .sim_dna (dna_value)
  ) i_id_top (
    .dclk    (dclk),
    .rst     (rst),
    .start   (start),
    .rd      (rd),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .done    (done)
  );

  always #(clk_period / 2) dclk = ~dclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected word per address from the register map rules
  function automatic word_t expected_word(input addr_t addr, input logic valid,
                                          input logic busy, input id_t dna);
    word_t w;
    w = '0;
    case (addr)
      2'd0: w = {30'd0, busy, valid};
      2'd1: if (valid) w = dna[31:0];                   // masked until the id is complete
      2'd2: if (valid) w = {7'd0, dna[56:32]};
      default: w = '0;
    endcase
    return w;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      fail_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_status(input id_status_t got, input id_status_t exp);
    if (got !== exp)
      fail_run($sformatf("ERR status got 0x%0h expected 0x%0h", got, exp));
  endtask

  task automatic check_done_total(input int exp, input string what);
    if (done_count != exp)
      fail_run($sformatf("%s: expected %0d done pulses in total but counted %0d",
                         what, exp, done_count));
  endtask

  // done counter and rd tracker on the rising edge
  always @(posedge dclk) begin
    if (done) done_count <= done_count + 1;
    rd_taken <= rd;                                     // rd_data is new after this edge
  end

  // compare at mid-cycle one cycle after each rd strobe
  always @(negedge dclk) begin
    if (rd_taken) begin
      if (exp_q.size() == 0)
        fail_run("read data arrived with no read outstanding");
      cmp_exp  = exp_q.pop_front();
      cmp_addr = addr_q.pop_front();
      if (cmp_addr == 2'd0)
        check_status(id_status_t'(rd_data[1:0]), id_status_t'(cmp_exp[1:0]));
      check_word($sformatf("rd_data addr %0d", cmp_addr), rd_data, cmp_exp);
    end
  end

  task automatic idle(input int n);
    repeat (n) @(posedge dclk);
  endtask

  task automatic pulse_reset();
    rst = 1'b1;
    repeat (8) @(posedge dclk);
    #5;
    rst       = 1'b0;
    exp_valid = 1'b0;                                   // reset drops any held id
    exp_busy  = 1'b0;
  endtask

  task automatic read_reg(input addr_t addr);
    @(posedge dclk);
    #5;
    rd      = 1'b1;
    rd_addr = addr;
    exp_q.push_back(expected_word(addr, exp_valid, exp_busy, dna_value));
    addr_q.push_back(addr);
    @(posedge dclk);
    #5;
    rd = 1'b0;
  endtask

  task automatic read_all();
    for (int a = 0; a < 4; a++) read_reg(addr_t'(a));
  endtask

  // short gaps keep a burst inside the busy window of a readout
  task automatic random_reads(input int n, input logic short_gaps);
    repeat (n) begin
      rng = xorshift32(rng);
      idle(short_gaps ? int'(rng[4]) : int'(rng[6:4]));
      read_reg(rng[1:0]);
    end
  endtask

  task automatic start_readout(input int len);
    @(posedge dclk);
    #5;
    start = 1'b1;
    repeat (len) @(posedge dclk);
    #5;
    start = 1'b0;
    repeat (3) @(posedge dclk);                         // sync, edge detect, load
    #5;
    exp_busy  = 1'b1;
    exp_valid = 1'b0;                                   // cleared when a readout begins
  endtask

  task automatic wait_done();
    int target;
    int waited;
    target = done_count + 1;
    waited = 0;
    while (done_count < target) begin
      @(posedge dclk);
      waited++;
      if (waited > done_limit)
        fail_run("done pulse did not arrive after a readout was started");
    end
    #5;
    exp_busy  = 1'b0;
    exp_valid = 1'b1;
  endtask

  initial begin
    #((n_readouts * readout_cycles + read_margin) * clk_period);
    fail_run("watchdog expired before the test sequence finished");
  end

  initial begin
    dclk       = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    rd         = 1'b0;
    rd_addr    = '0;
    exp_valid  = 1'b0;
    exp_busy   = 1'b0;
    rng        = 32'd5;
    pulse_reset();

    read_all();                                         // everything zero after reset

    start_readout(1);                                   // single readout
    read_all();                                         // busy set, id words hidden
    wait_done();
    read_all();                                         // id now visible
    check_done_total(1, "single start pulse");

    // start held high through and well past one readout
    done_before = done_count;
    @(posedge dclk);
    #5;
    start = 1'b1;
    repeat (3) @(posedge dclk);
    #5;
    exp_busy  = 1'b1;
    exp_valid = 1'b0;
    wait_done();
    idle(80);
    #5;
    check_done_total(done_before + 1, "start held high");
    start = 1'b0;
    idle(4);                                            // let the synchronizer see low

    // second rising edge while busy is dropped
    done_before = done_count;
    rng = xorshift32(rng);
    start_readout(1 + int'(rng[10:8]));
    @(posedge dclk);
    #5;
    start = 1'b1;
    repeat (2) @(posedge dclk);
    #5;
    start = 1'b0;
    wait_done();
    idle(70);
    check_done_total(done_before + 1, "start pulsed again while busy");
    read_all();

    // random reads while idle, during a readout and after it
    repeat (3) begin
      random_reads(12, 1'b0);
      rng = xorshift32(rng);
      start_readout(1 + int'(rng[10:8]));
      random_reads(3, 1'b1);
      wait_done();
    end
    random_reads(12, 1'b0);

    // reset in the middle of a readout
    start_readout(2);
    idle(15);
    @(posedge dclk);
    #5;
    pulse_reset();
    read_all();
    done_before = done_count;
    start_readout(2);
    wait_done();
    read_all();
    check_done_total(done_before + 1, "readout after mid-read reset");

    idle(2);                                            // drain the last compare
    if (exp_q.size() != 0) begin
      fail_run("reads still waiting for data at the end of the run");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* all.f */
id_pkg.sv
dna_port_model.sv
dna_reader.sv
id_regs.sv
id_top.sv
tb_id_top.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and judge the run by the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_id_top -f all.f -o sim_id \
  > build.log 2>&1 \
  && ./obj_dir/sim_id > sim.log 2>&1
grep -q "Result: PASSED" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
